/* hdl/bp_pkg.sv */
package bp_pkg;

  // instruction address width
  localparam int addr_width = 32;

  typedef logic [addr_width-1:0] addr_t;  // one instruction address

  // 2-bit saturating counter
  // 0, 1 predict not taken; 2, 3 predict taken
  typedef logic [1:0] counter_t;

  localparam counter_t counter_init = 2'd1;  // weakly not taken
  localparam counter_t counter_min  = 2'd0;
  localparam counter_t counter_max  = 2'd3;

  // fixed instruction size
  localparam int inst_bytes = 4;
  localparam int inst_shift = $clog2(inst_bytes);  // word offset bits in pc

  localparam addr_t inst_step = addr_t'(inst_bytes);  // pc+4 increment

endpackage

/* hdl/ghr.sv */
module ghr #(
  parameter int ghr_width = 8
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 is_branch,  // resolved branch from decode
  input  logic                 is_taken,
  output logic [ghr_width-1:0] ghr_value
);

  logic [ghr_width-1:0] shifted;

  // newest outcome enters at bit 0
  always_comb begin
    shifted = {ghr_value[ghr_width-2:0], is_taken};
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      ghr_value <= '0;
    end else if (is_branch) begin
      ghr_value <= shifted;
    end
  end

endmodule

/* hdl/pht.sv */
module pht #(
  parameter int ghr_width = 8
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [ghr_width-1:0] pht_index,       // lookup from current pc
  input  logic                 is_last_branch,  // update strobe from decode
  input  logic                 is_last_taken,
  input  logic [ghr_width-1:0] last_index,      // index used at prediction time
  output logic                 pht_taken
);

  localparam int entries = 1 << ghr_width;

  bp_pkg::counter_t counters [entries];
  bp_pkg::counter_t last_count;
  bp_pkg::counter_t next_count;

  // upper bit is the taken prediction
  assign pht_taken = counters[pht_index][1];

  // saturating step for the resolved entry
  always_comb begin
    last_count = counters[last_index];
    next_count = last_count;
    if (is_last_taken) begin
      if (last_count != bp_pkg::counter_max) begin
        next_count = last_count + 2'd1;
      end
    end else begin
      if (last_count != bp_pkg::counter_min) begin
        next_count = last_count - 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < entries; i++) begin
        counters[i] <= bp_pkg::counter_init;
      end
    end else if (is_last_branch) begin
      counters[last_index] <= next_count;
    end
  end

  // decode must hand back the index it got from fetch
  known_update_index: assert property (
    @(posedge clk) disable iff (!rst)
    is_last_branch |-> !$isunknown(last_index)
  );

endmodule

/* hdl/btb.sv */
module btb #(
  parameter int btb_index_width = 6
) (
  input  logic          clk,
  input  logic          rst,
  // lookup side
  input  bp_pkg::addr_t pc,
  // update side, from decode
  input  logic          is_branch,
  input  logic          is_jump,
  input  bp_pkg::addr_t inst_pc,
  input  bp_pkg::addr_t target,
  // lookup result
  output logic          hit_branch,
  output logic          hit_jump,
  output bp_pkg::addr_t hit_target
);

  localparam int entries   = 1 << btb_index_width;
  localparam int index_lsb = bp_pkg::inst_shift;
  localparam int tag_lsb   = btb_index_width + bp_pkg::inst_shift;
  localparam int tag_width = bp_pkg::addr_width - tag_lsb;

  logic                 valid_mem  [entries];
  logic [tag_width-1:0] tag_mem    [entries];
  logic                 jump_mem   [entries];
  bp_pkg::addr_t        target_mem [entries];

  logic [btb_index_width-1:0] rd_index;
  logic [tag_width-1:0]       rd_tag;
  logic [btb_index_width-1:0] wr_index;
  logic [tag_width-1:0]       wr_tag;
  logic                       hit;

  // split pc into index and tag, skipping the word offset
  assign rd_index = pc[tag_lsb-1:index_lsb];
  assign rd_tag   = pc[bp_pkg::addr_width-1:tag_lsb];
  assign wr_index = inst_pc[tag_lsb-1:index_lsb];
  assign wr_tag   = inst_pc[bp_pkg::addr_width-1:tag_lsb];

  assign hit        = valid_mem[rd_index] && (tag_mem[rd_index] == rd_tag);
  assign hit_branch = hit;
  assign hit_jump   = hit && jump_mem[rd_index];
  assign hit_target = target_mem[rd_index];

  // valid bits
  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < entries; i++) begin
        valid_mem[i] <= 1'b0;
      end
    end else if (is_branch) begin
      valid_mem[wr_index] <= 1'b1;
    end
  end

  // entry payload, meaningful only behind a valid bit
  always_ff @(posedge clk) begin
    if (is_branch) begin
      tag_mem[wr_index]    <= wr_tag;
      jump_mem[wr_index]   <= is_jump;
      target_mem[wr_index] <= target;
    end
  end

  // a jump from decode is always a branch, so it gets written
  jump_entry_is_branch: assert property (
    @(posedge clk) disable iff (!rst)
    is_jump |-> is_branch
  );

endmodule

/* hdl/bp_select.sv */
module bp_select #(
  parameter int ghr_width = 8
) (
  input  logic                 rst,
  input  bp_pkg::addr_t        pc,              // fetch pc
  // from decode
  input  logic                 is_branch,
  input  logic                 is_jump,         // j or jal
  input  logic                 is_taken,
  input  logic                 is_miss,
  input  logic [ghr_width-1:0] last_pht_index,
  input  bp_pkg::addr_t        inst_pc,
  input  bp_pkg::addr_t        target,
  // from history and tables
  input  logic [ghr_width-1:0] ghr_value,
  input  logic                 pht_taken,
  input  logic                 hit_branch,
  input  logic                 hit_jump,
  input  bp_pkg::addr_t        hit_target,
  // to ghr
  output logic                 ghr_is_branch,
  output logic                 ghr_is_taken,
  // to pht
  output logic                 pht_is_last_branch,
  output logic                 pht_is_last_taken,
  output logic [ghr_width-1:0] pht_last_index,
  output logic [ghr_width-1:0] pht_index,
  // to btb
  output logic                 btb_is_branch,
  output logic                 btb_is_jump,
  output bp_pkg::addr_t        btb_inst_pc,
  output bp_pkg::addr_t        btb_target,
  output bp_pkg::addr_t        btb_pc,
  // to fetch
  output logic                 is_branch_taken,
  output bp_pkg::addr_t        next_pc
);

  bp_pkg::addr_t seq_pc;

  // decode updates go straight to the tables
  assign ghr_is_branch      = is_branch;
  assign ghr_is_taken       = is_taken;
  assign pht_is_last_branch = is_branch;
  assign pht_is_last_taken  = is_taken;
  assign pht_last_index     = last_pht_index;
  assign btb_is_branch      = is_branch;
  assign btb_is_jump        = is_jump;
  assign btb_inst_pc        = inst_pc;
  assign btb_target         = target;
  assign btb_pc             = pc;

  // gshare hash
  assign pht_index = pc[ghr_width+bp_pkg::inst_shift-1:bp_pkg::inst_shift] ^ ghr_value;

  // jumps ignore the counter
  assign is_branch_taken = rst && hit_branch && (pht_taken || hit_jump);
  assign seq_pc          = pc + bp_pkg::inst_step;

  always_comb begin
    if (!rst) begin
      next_pc = seq_pc;
    end else if (is_miss) begin
      next_pc = target;  // correction beats any prediction
    end else if (is_branch_taken) begin
      next_pc = hit_target;
    end else begin
      next_pc = seq_pc;
    end
  end

  // a miss is only reported for a resolved branch
  always_comb begin
    miss_needs_branch: assert final (!rst || !is_miss || is_branch);
  end

endmodule

/* hdl/branch_predictor.sv */
module branch_predictor #(
  parameter int ghr_width       = 8,  // history length, pht has 2^ghr_width entries
  parameter int btb_index_width = 6   // btb has 2^btb_index_width entries
) (
  input  logic                 clk,
  input  logic                 rst,
  input  bp_pkg::addr_t        pc,
  // resolved instruction from decode
  input  logic                 is_branch,
  input  logic                 is_jump,
  input  logic                 is_taken,
  input  logic                 is_miss,
  input  logic [ghr_width-1:0] last_pht_index,
  input  bp_pkg::addr_t        inst_pc,
  input  bp_pkg::addr_t        target,
  // prediction for fetch
  output logic                 is_branch_taken,
  output logic [ghr_width-1:0] current_pht_index,
  output bp_pkg::addr_t        next_pc
);

  logic [ghr_width-1:0] ghr_value;
  logic                 ghr_is_branch;
  logic                 ghr_is_taken;

  logic                 pht_taken;
  logic                 pht_is_last_branch;
  logic                 pht_is_last_taken;
  logic [ghr_width-1:0] pht_last_index;
  logic [ghr_width-1:0] pht_index;

  logic                 hit_branch;
  logic                 hit_jump;
  bp_pkg::addr_t        hit_target;
  logic                 btb_is_branch;
  logic                 btb_is_jump;
  bp_pkg::addr_t        btb_inst_pc;
  bp_pkg::addr_t        btb_target;
  bp_pkg::addr_t        btb_pc;

  assign current_pht_index = pht_index;  // carried along with the fetched inst

  ghr #(
    .ghr_width (ghr_width)
  ) u_ghr (
    .clk       (clk),
    .rst       (rst),
    .is_branch (ghr_is_branch),
    .is_taken  (ghr_is_taken),
    .ghr_value (ghr_value)
  );

  pht #(
    .ghr_width (ghr_width)
  ) u_pht (
    .clk            (clk),
    .rst            (rst),
    .pht_index      (pht_index),
    .is_last_branch (pht_is_last_branch),
    .is_last_taken  (pht_is_last_taken),
    .last_index     (pht_last_index),
    .pht_taken      (pht_taken)
  );

  btb #(
    .btb_index_width (btb_index_width)
  ) u_btb (
    .clk        (clk),
    .rst        (rst),
    .pc         (btb_pc),
    .is_branch  (btb_is_branch),
    .is_jump    (btb_is_jump),
    .inst_pc    (btb_inst_pc),
    .target     (btb_target),
    .hit_branch (hit_branch),
    .hit_jump   (hit_jump),
    .hit_target (hit_target)
  );

  bp_select #(
    .ghr_width (ghr_width)
  ) u_bp_select (
    .rst                (rst),
    .pc                 (pc),
    .is_branch          (is_branch),
    .is_jump            (is_jump),
    .is_taken           (is_taken),
    .is_miss            (is_miss),
    .last_pht_index     (last_pht_index),
    .inst_pc            (inst_pc),
    .target             (target),
    .ghr_value          (ghr_value),
    .pht_taken          (pht_taken),
    .hit_branch         (hit_branch),
    .hit_jump           (hit_jump),
    .hit_target         (hit_target),
    .ghr_is_branch      (ghr_is_branch),
    .ghr_is_taken       (ghr_is_taken),
    .pht_is_last_branch (pht_is_last_branch),
    .pht_is_last_taken  (pht_is_last_taken),
    .pht_last_index     (pht_last_index),
    .pht_index          (pht_index),
    .btb_is_branch      (btb_is_branch),
    .btb_is_jump        (btb_is_jump),
    .btb_inst_pc        (btb_inst_pc),
    .btb_target         (btb_target),
    .btb_pc             (btb_pc),
    .is_branch_taken    (is_branch_taken),
    .next_pc            (next_pc)
  );

endmodule

/* test/tb_branch_predictor.sv */
module tb_branch_predictor;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ghr_width       = 8;
  localparam int btb_index_width = 6;
  localparam int tag_lsb         = btb_index_width + 2;  // above btb index and word offset
  localparam int num_cycles      = 2000;
  localparam int clk_period      = 40;

  logic                 clk;
  logic                 rst;
  bp_pkg::addr_t        pc;
  logic                 is_branch;
  logic                 is_jump;
  logic                 is_taken;
  logic                 is_miss;
  logic [ghr_width-1:0] last_pht_index;
  bp_pkg::addr_t        inst_pc;
  bp_pkg::addr_t        target;
  logic                 is_branch_taken;
  logic [ghr_width-1:0] current_pht_index;
  bp_pkg::addr_t        next_pc;

  // reference model state
  logic [ghr_width-1:0] m_ghr;
  bp_pkg::counter_t     m_cnt [1 << ghr_width];
  logic                 m_valid [1 << btb_index_width];
  logic [31-tag_lsb:0]  m_tag [1 << btb_index_width];
  logic                 m_jump [1 << btb_index_width];
  bp_pkg::addr_t        m_target [1 << btb_index_width];

  logic [ghr_width-1:0] slot_index [16];  // index seen at the last fetch of each pool pc
  logic [3:0]           fetch_slot;
  logic [31:0]          rand_state;

  branch_predictor #(
    .ghr_width       (ghr_width),
    .btb_index_width (btb_index_width)
  ) uut (
    .clk               (clk),
    .rst               (rst),
    .pc                (pc),
    .is_branch         (is_branch),
    .is_jump           (is_jump),
    .is_taken          (is_taken),
    .is_miss           (is_miss),
    .last_pht_index    (last_pht_index),
    .inst_pc           (inst_pc),
    .target            (target),
    .is_branch_taken   (is_branch_taken),
    .current_pht_index (current_pht_index),
    .next_pc           (next_pc)
  );

  always #(clk_period / 2) clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // upper half of the pool shares btb index with the lower half, different tag
  function automatic bp_pkg::addr_t pool_pc(input logic [3:0] slot);
    return 32'h0040_0000 + (slot[3] ? 32'h100 : 32'h0) + {slot[2:0], 2'b00};
  endfunction

  // same edge, same rules as history, counters and target buffer
  function automatic void update_model();
    logic [btb_index_width-1:0] bi;
    bi = inst_pc[btb_index_width+1:2];
    if (!rst) begin
      m_ghr = '0;
      for (int i = 0; i < (1 << ghr_width); i++) begin
        m_cnt[i] = bp_pkg::counter_init;
      end
      for (int i = 0; i < (1 << btb_index_width); i++) begin
        m_valid[i] = 1'b0;
      end
    end else if (is_branch) begin
      if (is_taken && m_cnt[last_pht_index] != 2'd3) begin
        m_cnt[last_pht_index] = m_cnt[last_pht_index] + 2'd1;
      end else if (!is_taken && m_cnt[last_pht_index] != 2'd0) begin
        m_cnt[last_pht_index] = m_cnt[last_pht_index] - 2'd1;
      end
      m_ghr       = {m_ghr[ghr_width-2:0], is_taken};  // newest outcome at bit 0
      m_valid[bi]  = 1'b1;
      m_tag[bi]    = inst_pc[31:tag_lsb];
      m_jump[bi]   = is_jump;
      m_target[bi] = target;
    end
  endfunction

  // expected prediction for the pc and decode inputs now applied
  function automatic void predict(input bp_pkg::addr_t p, input logic rst_now,
                                  input logic miss, input bp_pkg::addr_t tgt,
                                  output bp_pkg::addr_t exp_next, output logic exp_taken,
                                  output logic [ghr_width-1:0] exp_idx);
    logic [btb_index_width-1:0] bi;
    logic                       hit;
    exp_idx   = p[ghr_width+1:2] ^ m_ghr;
    bi        = p[btb_index_width+1:2];
    hit       = m_valid[bi] && (m_tag[bi] == p[31:tag_lsb]);
    exp_taken = rst_now && hit && (m_cnt[exp_idx] >= 2'd2 || m_jump[bi]);
    if (!rst_now) begin
      exp_next = p + 32'd4;
    end else if (miss) begin
      exp_next = tgt;
    end else if (exp_taken) begin
      exp_next = m_target[bi];
    end else begin
      exp_next = p + 32'd4;
    end
  endfunction

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic addr_check(input string name, input bp_pkg::addr_t expected,
                            input bp_pkg::addr_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("CHECK FAILED at %0d ns: %s expected %h actual %h",
                                  $time, name, expected, actual));
    end
  endtask

  task automatic flag_check(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("CHECK FAILED at %0d ns: %s expected %b actual %b",
                                  $time, name, expected, actual));
    end
  endtask

  task automatic index_check(input string name, input logic [ghr_width-1:0] expected,
                             input logic [ghr_width-1:0] actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("CHECK FAILED at %0d ns: %s expected %h actual %h",
                                  $time, name, expected, actual));
    end
  endtask

  // one fetch pc and maybe one resolved branch per cycle
  task automatic drive_inputs();
    logic [31:0] r;
    logic [3:0]  dec_slot;
    logic        take;
    rand_state = lcg_next(rand_state);
    r          = rand_state;
    fetch_slot = r[31:28];
    dec_slot   = r[27:24];
    pc <= pool_pc(r[31:28]);
    if (rst && r[23:22] != 2'b00) begin
      case (dec_slot[3:2])
        2'd0:    take = (r[21:19] != 3'd0);  // mostly taken
        2'd1:    take = r[21];
        2'd2:    take = (r[21:19] == 3'd0);  // mostly not taken
        default: take = 1'b1;                // jumps always go
      endcase
      is_branch      <= 1'b1;
      is_jump        <= (dec_slot[3:2] == 2'd3);
      is_taken       <= take;
      is_miss        <= (r[18:16] == 3'd0);
      last_pht_index <= slot_index[dec_slot];
      inst_pc        <= pool_pc(dec_slot);
      target         <= 32'h0080_0000 + {dec_slot, 6'd0} + (r[15] ? 32'h1000 : 32'h0);
    end else begin
      is_branch <= 1'b0;
      is_jump   <= 1'b0;
      is_taken  <= 1'b0;
      is_miss   <= 1'b0;
    end
  endtask

  initial begin
    clk            = 1'b0;
    rst            = 1'b0;
    pc             = pool_pc(4'd0);
    is_branch      = 1'b0;
    is_jump        = 1'b0;
    is_taken       = 1'b0;
    is_miss        = 1'b0;
    last_pht_index = '0;
    inst_pc        = '0;
    target         = '0;
    m_ghr          = '0;
    fetch_slot     = 4'd0;
    rand_state     = 32'hf013bdd9;
    for (int i = 0; i < 16; i++) begin
      slot_index[i] = '0;
    end
    for (int n = 0; n < num_cycles; n++) begin
      @(posedge clk);
      update_model();  // sees inputs from the previous edge
      if (n == 2) begin
        rst <= 1'b1;  // low for the first 3 edges
      end
      drive_inputs();
    end
    @(negedge clk);
    #2;
    $display("Regression passed");
    $finish;
  end

  // outputs are settled well after the falling edge
  always @(negedge clk) begin
    bp_pkg::addr_t        exp_next;
    logic                 exp_taken;
    logic [ghr_width-1:0] exp_idx;
    #1;
    predict(pc, rst, is_miss, target, exp_next, exp_taken, exp_idx);
    index_check("current_pht_index", exp_idx, current_pht_index);
    flag_check("is_branch_taken", exp_taken, is_branch_taken);
    addr_check("next_pc", exp_next, next_pc);
    slot_index[fetch_slot] = exp_idx;
  end

  initial begin
    #(2 * num_cycles * clk_period);
    stop_with_failure("test timed out before all cycles were run");
  end

endmodule

/* list.f */
hdl/bp_pkg.sv
hdl/ghr.sv
hdl/pht.sv
hdl/btb.sv
hdl/bp_select.sv
hdl/branch_predictor.sv
test/tb_branch_predictor.sv
